/* design/cachePkg.sv */
// data cache package with geometry, address and line views, and bus operations
package cachePkg;

	//////////////////////////////////////////////////////////////////////
	// geometry
	//////////////////////////////////////////////////////////////////////

	localparam int wordBits = 32;
	localparam int adrBits = 32;
	localparam int lineWords = 8;
	localparam int numLines = 16;

	// derived field widths
	localparam int byteBits = $clog2(wordBits / 8);
	localparam int wordSelBits = $clog2(lineWords);
	localparam int indexBits = $clog2(numLines);
	localparam int tagBits = adrBits - indexBits - wordSelBits - byteBits;

	//////////////////////////////////////////////////////////////////////
	// shared types
	//////////////////////////////////////////////////////////////////////

	// one address, raw for the bus or split for lookup
	typedef union packed {
		logic [adrBits-1:0] raw;
		struct packed {
			logic [tagBits-1:0] tag;
			logic [indexBits-1:0] index;
			logic [wordSelBits-1:0] wordSel;
			logic [byteBits-1:0] byteSel;
		} f;
	} adrT;

	// one line, flat block or word by word
	typedef union packed {
		logic [lineWords*wordBits-1:0] flat;
		logic [lineWords-1:0][wordBits-1:0] words;
	} cacheLineT;

	// what the bus master is asked to do
	typedef enum logic [2:0] {
		opIdle,
		opFill,
		opEvict,
		opUncRead,
		opUncWrite
	} busOpT;

endpackage

/* design/arrayIf.sv */
// control and status link between the miss controller and the line array
`timescale 1ns/1ps

interface arrayIf;

	// array actions, decided by the controller
	logic wordWrite;
	logic lineWrite;
	logic setDirty;
	logic selBusWord;

	// lookup results from the array
	logic hit;
	logic victimDirty;

	modport ctrl (
		output wordWrite, lineWrite, setDirty, selBusWord,
		input hit, victimDirty
	);

	modport array (
		input wordWrite, lineWrite, setDirty, selBusWord,
		output hit, victimDirty
	);

endinterface

/* design/busIf.sv */
// operation request and completion link between the miss controller and the bus master
`timescale 1ns/1ps

interface busIf;

	// held constant by the controller until done
	cachePkg::busOpT op;

	// pulses on the ack of the last word
	logic done;

	modport ctrl (
		output op,
		input done
	);

	modport bus (
		input op,
		output done,
		import isUncached
	);

	// single-word operations that bypass the array
	function automatic logic isUncached();
		return (op == cachePkg::opUncRead) || (op == cachePkg::opUncWrite);
	endfunction

endinterface

/* design/missController.sv */
// cache FSM that sequences hits, line fills, dirty evictions and uncached accesses
`timescale 1ns/1ps

module missController (
	input logic clk,
	input logic reset,
	input logic memRead,
	input logic memWrite,
	input logic cacheable,
	output logic stall,
	output logic miss,
	arrayIf.ctrl arr,
	busIf.ctrl bus
);

	typedef enum logic [2:0] {
		ready,
		fetch,
		evict,
		writeLine,
		uncBusy,
		uncDone
	} stateT;

	stateT state;
	stateT nextState;
	logic req;
	logic wordDone;

	assign req = memRead | memWrite;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ready;
		end else begin
			state <= nextState;
		end
	end

	// a write hit takes one stalled cycle, then the held request passes
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wordDone <= 1'b0;
		end else begin
			wordDone <= arr.wordWrite;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		stall = 1'b0;
		miss = 1'b0;
		arr.wordWrite = 1'b0;
		arr.lineWrite = 1'b0;
		arr.setDirty = 1'b0;
		arr.selBusWord = 1'b0;
		bus.op = cachePkg::opIdle;

		case (state)
			ready: begin
				if (req & cacheable & arr.hit) begin
					// read hits need nothing, readData is already there
					if (memWrite & ~wordDone) begin
						arr.wordWrite = 1'b1;
						arr.setDirty = 1'b1;
						stall = 1'b1;
					end
				end else if (req & cacheable) begin
					miss = 1'b1;
					stall = 1'b1;
					nextState = fetch;
				end else if (req) begin
					stall = 1'b1;
					nextState = uncBusy;
				end
			end

			fetch: begin
				stall = 1'b1;
				bus.op = cachePkg::opFill;
				// victim is still in the array until writeLine
				if (bus.done) begin
					nextState = arr.victimDirty ? evict : writeLine;
				end
			end

			evict: begin
				stall = 1'b1;
				bus.op = cachePkg::opEvict;
				if (bus.done) begin
					nextState = writeLine;
				end
			end

			writeLine: begin
				stall = 1'b1;
				arr.lineWrite = 1'b1;
				nextState = ready;
			end

			uncBusy: begin
				stall = 1'b1;
				bus.op = memRead ? cachePkg::opUncRead : cachePkg::opUncWrite;
				if (bus.done) begin
					nextState = uncDone;
				end
			end

			// uncached read word comes from the fill buffer
			uncDone: begin
				arr.selBusWord = 1'b1;
				nextState = ready;
			end

			default: begin
				nextState = ready;
			end
		endcase
	end

endmodule

/* design/lineArray.sv */
// direct-mapped line storage with tag compare, victim outputs and read-word mux
`timescale 1ns/1ps

module lineArray (
	input logic clk,
	input logic reset,
	input cachePkg::adrT adr,
	input logic [cachePkg::wordBits-1:0] writeData,
	input cachePkg::cacheLineT fillLine,
	output logic [cachePkg::wordBits-1:0] readData,
	output cachePkg::cacheLineT victimLine,
	output logic [cachePkg::tagBits-1:0] victimTag,
	arrayIf.array arr
);

	cachePkg::cacheLineT lines [cachePkg::numLines];
	logic [cachePkg::tagBits-1:0] tags [cachePkg::numLines];
	logic [cachePkg::numLines-1:0] valid;
	logic [cachePkg::numLines-1:0] dirty;
	logic [cachePkg::indexBits-1:0] idx;

	assign idx = adr.f.index;

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (arr.lineWrite) begin
			lines[idx] <= fillLine;
			tags[idx] <= adr.f.tag;
		end else if (arr.wordWrite) begin
			lines[idx].words[adr.f.wordSel] <= writeData;
		end
	end

	// a fill installs a clean line
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (arr.lineWrite) begin
			valid[idx] <= 1'b1;
			dirty[idx] <= 1'b0;
		end else if (arr.setDirty) begin
			dirty[idx] <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////////////////////////

	assign arr.hit = valid[idx] & (tags[idx] == adr.f.tag);
	assign arr.victimDirty = valid[idx] & dirty[idx];
	assign victimLine = lines[idx];
	assign victimTag = tags[idx];

	assign readData = arr.selBusWord ? fillLine.words[0] : lines[idx].words[adr.f.wordSel];

endmodule

/* design/busMaster.sv */
// word-by-word bus transfers for fills, evictions and uncached accesses
`timescale 1ns/1ps

module busMaster (
	input logic clk,
	input logic reset,
	input cachePkg::adrT adr,
	input logic [cachePkg::wordBits-1:0] writeData,
	input cachePkg::cacheLineT victimLine,
	input logic [cachePkg::tagBits-1:0] victimTag,
	output logic [cachePkg::adrBits-1:0] busAdr,
	output logic busRead,
	output logic busWrite,
	input logic busAck,
	input logic [cachePkg::wordBits-1:0] busRdata,
	output logic [cachePkg::wordBits-1:0] busWdata,
	output cachePkg::cacheLineT fillLine,
	busIf.bus bus
);

	logic [cachePkg::wordSelBits-1:0] cnt;
	logic lastWord;
	cachePkg::adrT lineAdr;
	cachePkg::cacheLineT fillBuf;

	assign busRead = (bus.op == cachePkg::opFill) || (bus.op == cachePkg::opUncRead);
	assign busWrite = (bus.op == cachePkg::opEvict) || (bus.op == cachePkg::opUncWrite);

	// uncached accesses are a single word
	assign lastWord = bus.isUncached() || (cnt == cachePkg::wordSelBits'(cachePkg::lineWords - 1));
	assign bus.done = busAck & lastWord & (busRead | busWrite);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt <= '0;
		end else if (bus.done) begin
			cnt <= '0;
		end else if (busAck) begin
			cnt <= cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// address and write data
	//////////////////////////////////////////////////////////////////////

	// line base from the request, or from the victim tag on eviction
	always_comb begin
		lineAdr = adr;
		lineAdr.f.wordSel = cnt;
		lineAdr.f.byteSel = '0;
		if (bus.op == cachePkg::opEvict) begin
			lineAdr.f.tag = victimTag;
		end
	end

	assign busAdr = bus.isUncached() ? adr.raw : lineAdr.raw;
	assign busWdata = (bus.op == cachePkg::opEvict) ? victimLine.words[cnt] : writeData;

	// fill buffer, uncached reads land in word 0
	always_ff @(posedge clk) begin
		if (busAck & busRead) begin
			fillBuf.words[cnt] <= busRdata;
		end
	end

	assign fillLine = fillBuf;

endmodule

/* design/dataCache.sv */
// L1 data cache top level joining the FSM, the line array and the bus master
`timescale 1ns/1ps

module dataCache (
	input logic clk,
	input logic reset,

	// CPU side
	input logic memRead,
	input logic memWrite,
	input logic cacheable,
	input cachePkg::adrT adr,
	input logic [cachePkg::wordBits-1:0] writeData,
	output logic [cachePkg::wordBits-1:0] readData,
	output logic stall,
	output logic miss,

	// bus side
	output logic [cachePkg::adrBits-1:0] busAdr,
	output logic busRead,
	output logic busWrite,
	input logic busAck,
	input logic [cachePkg::wordBits-1:0] busRdata,
	output logic [cachePkg::wordBits-1:0] busWdata
);

	cachePkg::cacheLineT fillLine;
	cachePkg::cacheLineT victimLine;
	logic [cachePkg::tagBits-1:0] victimTag;

	arrayIf arrLink ();
	busIf busLink ();

	missController controller (
		.clk(clk),
		.reset(reset),
		.memRead(memRead),
		.memWrite(memWrite),
		.cacheable(cacheable),
		.stall(stall),
		.miss(miss),
		.arr(arrLink.ctrl),
		.bus(busLink.ctrl)
	);

	lineArray lines (
		.clk(clk),
		.reset(reset),
		.adr(adr),
		.writeData(writeData),
		.fillLine(fillLine),
		.readData(readData),
		.victimLine(victimLine),
		.victimTag(victimTag),
		.arr(arrLink.array)
	);

	busMaster master (
		.clk(clk),
		.reset(reset),
		.adr(adr),
		.writeData(writeData),
		.victimLine(victimLine),
		.victimTag(victimTag),
		.busAdr(busAdr),
		.busRead(busRead),
		.busWrite(busWrite),
		.busAck(busAck),
		.busRdata(busRdata),
		.busWdata(busWdata),
		.fillLine(fillLine),
		.bus(busLink.bus)
	);

endmodule

/* dv/cacheProps.sv */
// bus and stall assertions for the data cache, bound into the FSM and the bus master
`timescale 1ns/1ps

module cacheProps (
	input logic clk,
	input logic reset,
	input logic req,
	input logic stall,
	input logic miss,
	input logic busRead,
	input logic busWrite,
	input logic busAck,
	input logic [cachePkg::adrBits-1:0] busAdr
);

	// one direction at a time on the bus
	busExclusive: assert property (@(posedge clk) disable iff (reset)
		!(busRead && busWrite))
		else $error("busRead and busWrite high together");

	// address held until the word is acknowledged
	adrHeld: assert property (@(posedge clk) disable iff (reset)
		(busRead || busWrite) && !busAck |=> $stable(busAdr))
		else $error("busAdr changed while waiting for busAck");

	missPulse: assert property (@(posedge clk) disable iff (reset)
		miss |=> !miss)
		else $error("miss high for more than one cycle");

	// no request, no stall
	idleNoStall: assert property (@(posedge clk) disable iff (reset)
		!req |-> !stall)
		else $error("stall high without a request");

endmodule

/* dv/tbCache.sv */
// testbench for the L1 data cache with a bus memory model and directed tests
`timescale 1ns/1ps

module tbCache;

	localparam int period = 40;
	localparam int sampleDelay = 10;
	localparam int stallLimit = 200;
	localparam int memWords = 1024;
	localparam int mixCount = 60;
	// nine directed accesses plus the random mix, each with a 40 cycle budget
	localparam int plannedAccesses = 9 + mixCount;
	localparam int cyclesPerAccess = 40;

	logic clk;
	logic reset;
	logic memRead;
	logic memWrite;
	logic cacheable;
	cachePkg::adrT adr;
	logic [cachePkg::wordBits-1:0] writeData;
	logic [cachePkg::wordBits-1:0] readData;
	logic stall;
	logic miss;
	logic [cachePkg::adrBits-1:0] busAdr;
	logic busRead;
	logic busWrite;
	logic busAck;
	logic [cachePkg::wordBits-1:0] busRdata;
	logic [cachePkg::wordBits-1:0] busWdata;

	logic [cachePkg::wordBits-1:0] busMem [memWords];
	logic [cachePkg::wordBits-1:0] refMem [memWords];
	logic modelValid [cachePkg::numLines];
	logic [cachePkg::tagBits-1:0] modelTag [cachePkg::numLines];
	int seed = 32'h5fca;
	int ackDelay = -1;
	int missCount = 0;
	int expMisses = 0;
	int busWrites = 0;
	cachePkg::adrT lastWriteAdr;

	dataCache uut (
		.clk(clk),
		.reset(reset),
		.memRead(memRead),
		.memWrite(memWrite),
		.cacheable(cacheable),
		.adr(adr),
		.writeData(writeData),
		.readData(readData),
		.stall(stall),
		.miss(miss),
		.busAdr(busAdr),
		.busRead(busRead),
		.busWrite(busWrite),
		.busAck(busAck),
		.busRdata(busRdata),
		.busWdata(busWdata)
	);

	// stall and miss checks inside the FSM
	bind missController cacheProps ctrlProps (
		.clk(clk),
		.reset(reset),
		.req(req),
		.stall(stall),
		.miss(miss),
		.busRead(1'b0),
		.busWrite(1'b0),
		.busAck(1'b0),
		.busAdr('0)
	);

	bind busMaster cacheProps busProps (
		.clk(clk),
		.reset(reset),
		.req(1'b0),
		.stall(1'b0),
		.miss(1'b0),
		.busRead(busRead),
		.busWrite(busWrite),
		.busAck(busAck),
		.busAdr(busAdr)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] fillPattern(input logic [31:0] a);
		return {a[15:0] ^ 16'hc0de, a[15:0]};
	endfunction

	function automatic int memIndex(input logic [31:0] a);
		return int'(a[11:2]);
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkWord(input string name, input logic [cachePkg::wordBits-1:0] got,
			input logic [cachePkg::wordBits-1:0] exp);
		if (got !== exp) begin
			failRun($sformatf("mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic checkAdr(input string name, input cachePkg::adrT got,
			input cachePkg::adrT exp);
		if (got.raw !== exp.raw) begin
			failRun($sformatf("mismatch %s: got %h expected %h", name, got.raw, exp.raw));
		end
	endtask

	// one sample per cycle, midway between the falling and the rising edge
	task automatic waitStallLow(output int cycles);
		cycles = 0;
		#(sampleDelay);
		while (stall) begin
			if (miss) begin
				missCount++;
			end
			cycles++;
			if (cycles > stallLimit) begin
				failRun("stall stayed high past the cycle limit");
			end
			@(negedge clk);
			#(sampleDelay);
		end
	endtask

	task automatic access(input logic isWrite, input logic isCached, input logic [31:0] a,
			input logic [31:0] wdata, output int cycles);
		cachePkg::adrT view;
		int widx;
		view.raw = a;
		widx = memIndex(a);
		// direct-mapped tag model predicts the miss
		if (isCached && !(modelValid[view.f.index] && modelTag[view.f.index] == view.f.tag)) begin
			expMisses++;
		end
		@(negedge clk);
		memRead = ~isWrite;
		memWrite = isWrite;
		cacheable = isCached;
		adr.raw = a;
		writeData = wdata;
		waitStallLow(cycles);
		if (isWrite) begin
			refMem[widx] = wdata;
		end else begin
			checkWord("readData", readData, refMem[widx]);
		end
		if (isCached) begin
			modelValid[view.f.index] = 1'b1;
			modelTag[view.f.index] = view.f.tag;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus memory model
	//////////////////////////////////////////////////////////////////////

	// each word answered after 0 to 2 idle cycles
	initial begin
		busAck = 1'b0;
		busRdata = '0;
		forever begin
			@(negedge clk);
			busAck = 1'b0;
			if (!reset && (busRead || busWrite)) begin
				if (busAdr[cachePkg::adrBits-1:12] != '0) begin
					failRun("bus address outside the memory model");
				end
				if (ackDelay < 0) begin
					ackDelay = $unsigned($random(seed)) % 3;
				end
				if (ackDelay == 0) begin
					busAck = 1'b1;
					ackDelay = -1;
					if (busWrite) begin
						busMem[memIndex(busAdr)] = busWdata;
						busWrites++;
						lastWriteAdr.raw = busAdr;
					end else begin
						busRdata = busMem[memIndex(busAdr)];
					end
				end else begin
					ackDelay--;
				end
			end
		end
	end

	initial begin : watchdog
		#(plannedAccesses * cyclesPerAccess * period + 10 * period);
		failRun("watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic coldMissThenHit();
		int cycles;
		access(1'b0, 1'b1, 32'h0000_004c, '0, cycles);
		checkWord("missCount", 32'(missCount), 32'(expMisses));
		// same line, another word
		access(1'b0, 1'b1, 32'h0000_0054, '0, cycles);
		checkWord("stallCycles", 32'(cycles), 32'd0);
	endtask

	task automatic writeHitThenRead();
		int cycles;
		int writesBefore;
		writesBefore = busWrites;
		access(1'b1, 1'b1, 32'h0000_0044, 32'h600d_f00d, cycles);
		checkWord("stallCycles", 32'(cycles), 32'd1);
		access(1'b0, 1'b1, 32'h0000_0044, '0, cycles);
		checkWord("stallCycles", 32'(cycles), 32'd0);
		checkWord("busWrites", 32'(busWrites), 32'(writesBefore));
	endtask

	task automatic dirtyEviction();
		int cycles;
		cachePkg::adrT expAdr;
		access(1'b1, 1'b1, 32'h0000_00c8, 32'hdead_0001, cycles);
		// same index, next tag
		access(1'b0, 1'b1, 32'h0000_02c8, '0, cycles);
		expAdr.raw = 32'h0000_00dc;
		checkAdr("busAdr", lastWriteAdr, expAdr);
		checkWord("missCount", 32'(missCount), 32'(expMisses));
		access(1'b0, 1'b0, 32'h0000_00c8, '0, cycles);
	endtask

	task automatic uncachedWriteRead();
		int cycles;
		cachePkg::adrT expAdr;
		access(1'b1, 1'b0, 32'h0000_0810, 32'h1234_abcd, cycles);
		checkWord("busMem", busMem[memIndex(32'h0000_0810)], 32'h1234_abcd);
		expAdr.raw = 32'h0000_0810;
		checkAdr("busAdr", lastWriteAdr, expAdr);
		access(1'b0, 1'b0, 32'h0000_0810, '0, cycles);
	endtask

	// cached region below 0x800 over four indices, uncached words from 0x800
	task automatic randomMix();
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] d;
		logic isWrite;
		logic isCached;
		int cycles;
		for (int i = 0; i < mixCount; i++) begin
			r = $random(seed);
			d = $random(seed);
			isWrite = r[0];
			isCached = (r[3:1] > 3'd1);
			if (isCached) begin
				a = {21'd0, r[10:9], 2'b00, r[8:7], r[6:4], 2'b00};
			end else begin
				a = {20'd0, 6'b100000, r[7:4], 2'b00};
			end
			access(isWrite, isCached, a, d, cycles);
		end
		checkWord("missCount", 32'(missCount), 32'(expMisses));
	endtask

	initial begin
		reset = 1'b1;
		memRead = 1'b0;
		memWrite = 1'b0;
		cacheable = 1'b0;
		adr = '0;
		writeData = '0;
		lastWriteAdr = '0;
		for (int i = 0; i < memWords; i++) begin
			busMem[i] = fillPattern(i * 4);
			refMem[i] = fillPattern(i * 4);
		end
		for (int i = 0; i < cachePkg::numLines; i++) begin
			modelValid[i] = 1'b0;
			modelTag[i] = '0;
		end
		repeat (4) @(negedge clk);
		reset = 1'b0;

		coldMissThenHit();
		writeHitThenRead();
		dirtyEviction();
		uncachedWriteRead();
		randomMix();

		$display("TEST OK");
		$finish;
	end

endmodule

/* tb.f */
design/cachePkg.sv
design/arrayIf.sv
design/busIf.sv
design/missController.sv
design/lineArray.sv
design/busMaster.sv
design/dataCache.sv
dv/cacheProps.sv
dv/tbCache.sv

/* Makefile */
# Verilator build and run of the data cache testbench

SIM      = verilator
SIMFLAGS = --binary --timing --assert -j 0
TOP      = tbCache
FILELIST = tb.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q '^TEST OK$$'

clean:
	rm -rf $(OBJDIR)
